// File: source/uart_bridge_pkg.sv
package uart_bridge_pkg;

    // one word is one uart frame
    localparam int DATA_WIDTH       = 8;
    localparam int DATA_COUNT_WIDTH = $clog2(DATA_WIDTH) + 1;
    // terminal counts, sized to the counters
    localparam logic [DATA_COUNT_WIDTH-1:0] DATA_COUNT_LAST = DATA_COUNT_WIDTH'(DATA_WIDTH - 1);
    localparam logic [DATA_COUNT_WIDTH-1:0] DATA_COUNT_FULL = DATA_COUNT_WIDTH'(DATA_WIDTH);

    // slaves sharing the interconnect
    localparam int SLAVES     = 3;
    localparam int S_ID_WIDTH = $clog2(SLAVES + 1);
    localparam logic [S_ID_WIDTH-1:0] SLAVE_ID_DEFAULT = S_ID_WIDTH'(1);

    // command codes, sent msb first on control
    localparam int CMD_WIDTH = 3;
    localparam logic [CMD_WIDTH-1:0] CMD_START    = 3'b111;
    localparam logic [CMD_WIDTH-1:0] CMD_HOLD     = 3'b110;
    localparam logic [CMD_WIDTH-1:0] CMD_CONTINUE = 3'b101;
    localparam logic [CMD_WIDTH-1:0] CMD_ABORT    = 3'b100;

    // command, identity, then direction bit
    localparam int CON_WIDTH       = CMD_WIDTH + S_ID_WIDTH + 1;
    localparam int CON_COUNT_WIDTH = $clog2(CON_WIDTH + 1);
    localparam logic [CON_COUNT_WIDTH-1:0] CMD_COUNT_LAST = CON_COUNT_WIDTH'(CMD_WIDTH - 1);
    localparam logic [CON_COUNT_WIDTH-1:0] CON_COUNT_LAST = CON_COUNT_WIDTH'(CON_WIDTH - 1);

    // uart bit timing
    localparam int CLKS_PER_BIT = 4;
    localparam int FRAME_BITS   = DATA_WIDTH + 2;
    // one extra bit so the first sample delay of 1.5 bits fits
    localparam int BAUD_COUNT_WIDTH = $clog2(CLKS_PER_BIT) + 1;
    localparam logic [BAUD_COUNT_WIDTH-1:0] BAUD_LAST = BAUD_COUNT_WIDTH'(CLKS_PER_BIT - 1);
    // from start edge seen after the synchronizer to middle of bit 0
    localparam logic [BAUD_COUNT_WIDTH-1:0] BAUD_FIRST_SAMPLE =
        BAUD_COUNT_WIDTH'(CLKS_PER_BIT + CLKS_PER_BIT / 2 - 2);
    localparam logic [DATA_COUNT_WIDTH-1:0] FRAME_COUNT_LAST = DATA_COUNT_WIDTH'(FRAME_BITS - 1);

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   rx_line,
    input  logic                                   rx_take,
    output logic                                   rx_valid,
    output logic [uart_bridge_pkg::DATA_WIDTH-1:0] rx_data
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;

    // two-flop synchronizer, idle level is high
    logic line_meta;
    logic line_s;

    logic [uart_bridge_pkg::BAUD_COUNT_WIDTH-1:0] baud_cnt;
    logic [uart_bridge_pkg::DATA_COUNT_WIDTH-1:0] bit_cnt;
    logic [uart_bridge_pkg::DATA_WIDTH-1:0]       shift_q;

    logic sample_en;
    logic stop_done;

    // mid-bit points
    assign sample_en = (state == RX_DATA) && (baud_cnt == '0);
    assign stop_done = (state == RX_STOP) && (baud_cnt == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            line_meta <= 1'b1;
            line_s    <= 1'b1;
        end else begin
            line_meta <= rx_line;
            line_s    <= line_meta;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // word taken by the slave port
            if (rx_take) begin
                rx_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    // falling start edge, wait for middle of bit 0
                    if (!line_s) begin
                        baud_cnt <= uart_bridge_pkg::BAUD_FIRST_SAMPLE;
                        bit_cnt  <= '0;
                        state    <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == '0) begin
                        baud_cnt <= uart_bridge_pkg::BAUD_LAST;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == uart_bridge_pkg::DATA_COUNT_LAST) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == '0) begin
                        // frame dropped when the last word is still held
                        if (!rx_valid) begin
                            rx_valid <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (sample_en) begin
            shift_q <= {line_s, shift_q[uart_bridge_pkg::DATA_WIDTH-1:1]};
        end
        if (stop_done && !rx_valid) begin
            rx_data <= shift_q;
        end
    end

endmodule

// File: source/bus_slave_port.sv
`timescale 1ns/1ps

module bus_slave_port #(
    parameter logic [uart_bridge_pkg::S_ID_WIDTH-1:0] SLAVE_ID =
        uart_bridge_pkg::SLAVE_ID_DEFAULT
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    // master side, serial
    input  logic                                   control,
    input  logic                                   wD,
    input  logic                                   valid,
    output logic                                   rD,
    output logic                                   ready,
    // toward uart transmitter
    input  logic                                   tx_ready,
    output logic                                   tx_start,
    output logic [uart_bridge_pkg::DATA_WIDTH-1:0] tx_data,
    // from uart receiver
    input  logic                                   rx_valid,
    input  logic [uart_bridge_pkg::DATA_WIDTH-1:0] rx_data,
    output logic                                   rx_take
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RECONFIG,
        ST_CONFIG_NEXT,
        ST_READ,
        ST_WRITE,
        ST_READ_ACK
    } state_t;

    state_t state;
    // where CONTINUE goes back to
    state_t prev_state;
    logic   hold_q;

    // control sequence shift register
    logic [uart_bridge_pkg::CON_WIDTH-1:0]       con_q;
    logic [uart_bridge_pkg::CON_WIDTH-1:0]       con_next;
    logic [uart_bridge_pkg::CON_COUNT_WIDTH-1:0] con_cnt;

    // write word, msb first from wD
    logic [uart_bridge_pkg::DATA_WIDTH-1:0]       wd_q;
    logic [uart_bridge_pkg::DATA_COUNT_WIDTH-1:0] wd_cnt;

    // read word, msb first onto rD
    logic [uart_bridge_pkg::DATA_WIDTH-1:0]       rd_q;
    logic [uart_bridge_pkg::DATA_COUNT_WIDTH-1:0] rd_cnt;

    // current control bit appended
    assign con_next = {con_q[uart_bridge_pkg::CON_WIDTH-2:0], control};
    assign tx_data  = wd_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= ST_IDLE;
            prev_state <= ST_IDLE;
            hold_q     <= 1'b0;
            con_q      <= '0;
            con_cnt    <= '0;
            wd_q       <= '0;
            wd_cnt     <= '0;
            rd_q       <= '0;
            rd_cnt     <= '0;
            rD         <= 1'b0;
            ready      <= 1'b1;
            tx_start   <= 1'b0;
            rx_take    <= 1'b0;
        end else begin
            // single-cycle strobes
            tx_start <= 1'b0;
            rx_take  <= 1'b0;

            // high control bit outside a sequence opens a new one
            if (state != ST_RECONFIG && control) begin
                con_q      <= con_next;
                con_cnt    <= 1;
                prev_state <= state;
                state      <= ST_RECONFIG;
            end else begin
                case (state)
                    ST_IDLE: begin
                        ready  <= 1'b1;
                        rD     <= 1'b0;
                        // partial words are lost here
                        wd_cnt <= '0;
                        rd_cnt <= '0;
                    end
                    ST_RECONFIG: begin
                        // count 0 only while held, waiting for the next sequence
                        if (con_cnt != '0 || control) begin
                            con_q   <= con_next;
                            con_cnt <= con_cnt + 1'b1;
                            if (con_cnt == uart_bridge_pkg::CMD_COUNT_LAST) begin
                                // command complete
                                if (con_next[2:0] == uart_bridge_pkg::CMD_HOLD) begin
                                    hold_q  <= 1'b1;
                                    con_cnt <= '0;
                                end else if (con_next[2:0] == uart_bridge_pkg::CMD_CONTINUE) begin
                                    hold_q <= 1'b0;
                                    state  <= prev_state;
                                end else if (con_next[2:0] != uart_bridge_pkg::CMD_START) begin
                                    // abort
                                    hold_q <= 1'b0;
                                    state  <= ST_IDLE;
                                end
                            end else if (con_cnt == uart_bridge_pkg::CON_COUNT_LAST) begin
                                con_cnt <= '0;
                                // a START while held is read and ignored
                                if (!hold_q) begin
                                    if (con_next[uart_bridge_pkg::S_ID_WIDTH:1] == SLAVE_ID) begin
                                        wd_cnt <= '0;
                                        rd_cnt <= '0;
                                        // direction bit, 1 writes to uart
                                        if (con_next[0]) begin
                                            ready <= 1'b1;
                                            state <= ST_WRITE;
                                        end else begin
                                            ready <= 1'b0;
                                            state <= ST_CONFIG_NEXT;
                                        end
                                    end else begin
                                        // addressed to another slave
                                        state <= ST_IDLE;
                                    end
                                end
                            end
                        end
                    end
                    ST_CONFIG_NEXT: begin
                        // read set up, wait for a received word
                        if (rx_valid) begin
                            rx_take <= 1'b1;
                            rD      <= rx_data[uart_bridge_pkg::DATA_WIDTH-1];
                            rd_q    <= {rx_data[uart_bridge_pkg::DATA_WIDTH-2:0], 1'b0};
                            rd_cnt  <= 1;
                            ready   <= 1'b1;
                            state   <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        if (rd_cnt == uart_bridge_pkg::DATA_COUNT_FULL) begin
                            ready <= 1'b0;
                            rD    <= 1'b0;
                            state <= ST_READ_ACK;
                        end else begin
                            rD     <= rd_q[uart_bridge_pkg::DATA_WIDTH-1];
                            rd_q   <= {rd_q[uart_bridge_pkg::DATA_WIDTH-2:0], 1'b0};
                            rd_cnt <= rd_cnt + 1'b1;
                        end
                    end
                    ST_READ_ACK: begin
                        // one valid pulse closes the read
                        if (valid) begin
                            ready <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                    ST_WRITE: begin
                        if (wd_cnt == uart_bridge_pkg::DATA_COUNT_FULL) begin
                            // word complete, transmitter was busy
                            if (tx_ready) begin
                                tx_start <= 1'b1;
                                state    <= ST_IDLE;
                            end
                        end else if (valid) begin
                            wd_q   <= {wd_q[uart_bridge_pkg::DATA_WIDTH-2:0], wD};
                            wd_cnt <= wd_cnt + 1'b1;
                            // last bit, hand over right away when possible
                            if (wd_cnt == uart_bridge_pkg::DATA_COUNT_LAST && tx_ready) begin
                                tx_start <= 1'b1;
                                state    <= ST_IDLE;
                            end
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   tx_start,
    input  logic [uart_bridge_pkg::DATA_WIDTH-1:0] tx_data,
    output logic                                   tx_ready,
    output logic                                   tx_line
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t state;

    logic [uart_bridge_pkg::BAUD_COUNT_WIDTH-1:0] baud_cnt;
    // index of the bit on the line, 0 is the start bit
    logic [uart_bridge_pkg::DATA_COUNT_WIDTH-1:0] bit_cnt;
    logic [uart_bridge_pkg::DATA_WIDTH-1:0]       data_q;

    logic load;
    logic bit_end;

    assign load     = (state == TX_IDLE) && tx_start;
    assign bit_end  = (state == TX_SEND) && (baud_cnt == uart_bridge_pkg::BAUD_LAST);
    assign tx_ready = (state == TX_IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_line  <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_line <= 1'b1;
                    // start bit on the line next cycle
                    if (tx_start) begin
                        tx_line  <= 1'b0;
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == uart_bridge_pkg::FRAME_COUNT_LAST) begin
                            // stop bit done
                            state <= TX_IDLE;
                        end else if (bit_cnt == uart_bridge_pkg::DATA_COUNT_FULL) begin
                            tx_line <= 1'b1;
                        end else begin
                            tx_line <= data_q[0];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // word latched on start, lsb leaves first
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= tx_data;
        end else if (bit_end) begin
            data_q <= {1'b0, data_q[uart_bridge_pkg::DATA_WIDTH-1:1]};
        end
    end

endmodule

// File: source/uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge (
    input  logic clk,
    input  logic rstN,
    // master bus
    input  logic control,
    input  logic wD,
    input  logic valid,
    output logic rD,
    output logic ready,
    // serial lines
    input  logic uart_rx_line,
    output logic uart_tx_line
);

    // receiver to slave port
    logic                                   rx_valid;
    logic                                   rx_take;
    logic [uart_bridge_pkg::DATA_WIDTH-1:0] rx_data;

    // slave port to transmitter
    logic                                   tx_start;
    logic                                   tx_ready;
    logic [uart_bridge_pkg::DATA_WIDTH-1:0] tx_data;

    uart_rx rx0 (
        .clk      (clk),
        .rstN     (rstN),
        .rx_line  (uart_rx_line),
        .rx_take  (rx_take),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    bus_slave_port #(
        .SLAVE_ID (uart_bridge_pkg::SLAVE_ID_DEFAULT)
    ) port0 (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .wD       (wD),
        .valid    (valid),
        .rD       (rD),
        .ready    (ready),
        .tx_ready (tx_ready),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_take  (rx_take)
    );

    uart_tx tx0 (
        .clk      (clk),
        .rstN     (rstN),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .tx_line  (uart_tx_line)
    );

endmodule

// File: tests/tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge;

    typedef logic [uart_bridge_pkg::DATA_WIDTH-1:0] word_t;
    typedef logic [uart_bridge_pkg::S_ID_WIDTH-1:0] slave_id_t;

    localparam logic [31:0] SEED       = 32'h13549068;
    localparam int          WAIT_LIMIT = 200;
    localparam int          CPB        = uart_bridge_pkg::CLKS_PER_BIT;
    // start, data and stop bits
    localparam int          FRAME_CLKS = (uart_bridge_pkg::DATA_WIDTH + 2) * CPB;
    localparam slave_id_t   OWN_ID     = 1;
    localparam slave_id_t   OTHER_ID   = 2;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic uart_rx_line;
    logic rD;
    logic ready;
    logic uart_tx_line;

    int errors;
    int checks;
    int tests;
    int errors_at_start;

    uart_bridge dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .control      (control),
        .wD           (wD),
        .valid        (valid),
        .rD           (rD),
        .ready        (ready),
        .uart_rx_line (uart_rx_line),
        .uart_tx_line (uart_tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
    endtask

    // control sequence, msb first, one bit per cycle
    task automatic send_control(input logic [7:0] seq, input int len);
        for (int i = len - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= seq[i];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic send_start(input slave_id_t id, input logic to_uart);
        send_control({2'b00, uart_bridge_pkg::CMD_START, id, to_uart}, 6);
    endtask

    task automatic send_command(input logic [2:0] cmd);
        send_control({5'b00000, cmd}, 3);
    endtask

    // bits first down to last of the word on wD, valid high
    task automatic write_bits(input word_t word, input int first, input int last);
        for (int i = first; i >= last; i--) begin
            @(posedge clk);
            wD    <= word[i];
            valid <= 1'b1;
        end
        @(posedge clk);
        valid <= 1'b0;
        wD    <= 1'b0;
    endtask

    // outputs sampled on the falling edge
    task automatic wait_ready(input string what, output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (ready === 1'b1);
        if (!ok) begin
            report_timeout(what);
        end
    endtask

    task automatic read_word(output word_t word, output bit ok);
        word = '0;
        wait_ready("ready with the read word", ok);
        if (ok) begin
            // msb first, one bit per cycle while ready is high
            for (int i = uart_bridge_pkg::DATA_WIDTH - 1; i >= 0; i--) begin
                check_bit("ready during the read word", ready, 1'b1);
                word[i] = rD;
                @(negedge clk);
            end
            check_bit("ready after the read word", ready, 1'b0);
        end
    endtask

    task automatic pulse_ack();
        bit ok;
        @(posedge clk);
        valid <= 1'b1;
        @(posedge clk);
        valid <= 1'b0;
        wait_ready("ready after the acknowledge", ok);
    endtask

    // lsb first, each bit held CPB cycles
    task automatic drive_frame(input word_t word);
        @(posedge clk);
        uart_rx_line <= 1'b0;
        repeat (CPB - 1) @(posedge clk);
        for (int i = 0; i < uart_bridge_pkg::DATA_WIDTH; i++) begin
            @(posedge clk);
            uart_rx_line <= word[i];
            repeat (CPB - 1) @(posedge clk);
        end
        @(posedge clk);
        uart_rx_line <= 1'b1;
        repeat (CPB - 1) @(posedge clk);
    endtask

    task automatic capture_frame(output word_t word, output bit ok);
        int n;
        word = '0;
        n = 0;
        @(negedge clk);
        while (uart_tx_line !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (uart_tx_line === 1'b0);
        if (!ok) begin
            report_timeout("a start bit on uart_tx_line");
        end else begin
            // move to the middle of the start bit
            repeat (CPB / 2) @(negedge clk);
            check_bit("start bit", uart_tx_line, 1'b0);
            for (int i = 0; i < uart_bridge_pkg::DATA_WIDTH; i++) begin
                repeat (CPB) @(negedge clk);
                word[i] = uart_tx_line;
            end
            repeat (CPB) @(negedge clk);
            check_bit("stop bit", uart_tx_line, 1'b1);
        end
    endtask

    task automatic expect_no_frame();
        logic seen_low;
        seen_low = 1'b0;
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk);
            if (uart_tx_line !== 1'b1) begin
                seen_low = 1'b1;
            end
        end
        check_bit("start bit seen on uart_tx_line", seen_low, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s done with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("ready after reset", ready, 1'b1);
        check_bit("rD after reset", rD, 1'b0);
        check_bit("uart_tx_line after reset", uart_tx_line, 1'b1);
        end_test("reset");
    endtask

    task automatic test_write(input int count);
        word_t word;
        word_t got;
        bit    ok;
        repeat (count) begin
            word = word_t'($urandom());
            send_start(OWN_ID, 1'b1);
            write_bits(word, uart_bridge_pkg::DATA_WIDTH - 1, 0);
            capture_frame(got, ok);
            if (ok) begin
                check_word("transmitted word", got, word);
            end
        end
        end_test("write");
    endtask

    task automatic test_read();
        word_t word;
        word_t got;
        bit    ok;
        word = word_t'($urandom());
        drive_frame(word);
        send_start(OWN_ID, 1'b0);
        read_word(got, ok);
        if (ok) begin
            check_word("read word", got, word);
            pulse_ack();
        end
        end_test("read");
    endtask

    task automatic test_wrong_id();
        send_start(OTHER_ID, 1'b1);
        write_bits(word_t'($urandom()), uart_bridge_pkg::DATA_WIDTH - 1, 0);
        expect_no_frame();
        check_bit("ready after other identity", ready, 1'b1);
        end_test("wrong_id");
    endtask

    task automatic test_hold();
        word_t word;
        word_t got;
        bit    ok;
        word = word_t'($urandom());
        send_start(OWN_ID, 1'b1);
        write_bits(word, uart_bridge_pkg::DATA_WIDTH - 1, uart_bridge_pkg::DATA_WIDTH / 2);
        send_command(uart_bridge_pkg::CMD_HOLD);
        // bus noise while frozen
        repeat (6) begin
            @(posedge clk);
            wD    <= ~wD;
            valid <= 1'b1;
        end
        @(posedge clk);
        valid <= 1'b0;
        send_command(uart_bridge_pkg::CMD_CONTINUE);
        write_bits(word, uart_bridge_pkg::DATA_WIDTH / 2 - 1, 0);
        capture_frame(got, ok);
        if (ok) begin
            check_word("word after hold", got, word);
        end
        end_test("hold");
    endtask

    task automatic test_abort_loopback();
        word_t part;
        word_t word;
        word_t got;
        word_t back;
        bit    ok;
        part = word_t'($urandom());
        send_start(OWN_ID, 1'b1);
        write_bits(part, uart_bridge_pkg::DATA_WIDTH - 1, uart_bridge_pkg::DATA_WIDTH / 2);
        send_command(uart_bridge_pkg::CMD_ABORT);
        // rest of the aborted word lands in idle
        write_bits(part, uart_bridge_pkg::DATA_WIDTH / 2 - 1, 0);
        expect_no_frame();
        word = word_t'($urandom());
        send_start(OWN_ID, 1'b1);
        write_bits(word, uart_bridge_pkg::DATA_WIDTH - 1, 0);
        capture_frame(got, ok);
        if (ok) begin
            check_word("looped word out", got, word);
            // same frame back into the receiver
            drive_frame(got);
            send_start(OWN_ID, 1'b0);
            read_word(back, ok);
            if (ok) begin
                check_word("looped word back", back, word);
                pulse_ack();
            end
        end
        end_test("abort_loopback");
    endtask

    initial begin
        void'($urandom(SEED));
        errors          = 0;
        checks          = 0;
        tests           = 0;
        errors_at_start = 0;
        rstN            = 1'b0;
        control         = 1'b0;
        wD              = 1'b0;
        valid           = 1'b0;
        uart_rx_line    = 1'b1;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        test_reset();
        test_write(4);
        test_read();
        test_wrong_id();
        test_hold();
        test_abort_loopback();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: uart_bridge.f
source/uart_bridge_pkg.sv
source/uart_rx.sv
source/bus_slave_port.sv
source/uart_tx.sv
source/uart_bridge.sv
tests/tb_uart_bridge.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_uart_bridge
FILELIST  = uart_bridge.f

BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
